// ==== icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int num_ways   = 4;
    localparam int num_sets   = 128;
    localparam int line_words = 8;
    localparam int tag_bits   = 20;
    localparam int index_bits = 7;
    localparam int word_bits  = 3;

    // AR encodings
    localparam logic [7:0] burst_len_cached = 8'd7;
    localparam logic [7:0] burst_len_single = 8'd0;
    localparam logic [1:0] burst_fixed      = 2'b00;
    localparam logic [1:0] burst_incr       = 2'b01;

    // segments mapped by clearing the top three bits
    localparam logic [2:0] seg_kseg0 = 3'b100;
    localparam logic [2:0] seg_kseg1 = 3'b101;

    typedef logic [31:0] word_t;
    typedef logic [1:0]  way_idx_t;

    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [index_bits-1:0] index;
        logic [word_bits-1:0]  word_off;
        logic [1:0]            byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic [2:0]  segment;
        logic [28:0] phys;
    } seg_addr_t;

    // lookup view and segment view of the same fetch address
    typedef union packed {
        cache_addr_t cache;
        seg_addr_t   seg;
    } fetch_addr_u;

    typedef struct packed {
        fetch_addr_u addr;
        logic        cached;
    } fetch_req_t;

    typedef struct packed {
        logic     hit;
        way_idx_t hit_way;
        way_idx_t victim_way;
    } lookup_t;

    typedef struct packed {
        logic                 wen;
        way_idx_t             way;
        logic [word_bits-1:0] word;
        word_t                data;
    } beat_wr_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        single_ar,
        single_r,
        line_ar,
        line_r,
        tag_update,
        data_ready
    } ctrl_state_e;

endpackage

// ==== icache_addr_decode.sv ====
`timescale 1ns/1ps

module icache_addr_decode
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       accept,
    input  word_t      inst_addr,
    input  logic       inst_cached,
    output fetch_req_t req,
    output word_t      mapped_addr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            req <= '0;
        end else if (accept) begin
            req.addr   <= inst_addr;
            req.cached <= inst_cached;
        end
    end

    // kseg0/kseg1 fold onto the low physical space
    always_comb begin
        mapped_addr = req.addr;
        if (req.addr.seg.segment == seg_kseg0 || req.addr.seg.segment == seg_kseg1) begin
            mapped_addr = {3'b000, req.addr.seg.phys};
        end
    end

endmodule

// ==== icache_tag_lru.sv ====
`timescale 1ns/1ps

module icache_tag_lru
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       accept,
    input  word_t      inst_addr,
    input  fetch_req_t req,
    input  logic       lookup_en,
    input  logic       tag_wen,
    output lookup_t    look
);

    fetch_addr_u           in_addr;
    logic [tag_bits-1:0]   tag_mem [num_ways][num_sets];
    logic [tag_bits-1:0]   rd_tag [num_ways];
    logic [num_sets-1:0]   valid_q [num_ways];
    logic [num_sets-1:0]   lru_root;
    logic [num_sets-1:0]   lru_grp [2];
    logic [index_bits-1:0] idx;
    logic [num_ways-1:0]   hit_vec;
    logic                  root;

    assign in_addr = inst_addr;
    assign idx     = req.addr.cache.index;
    assign root    = lru_root[idx];

    // tags read at the incoming index, written into the victim after refill
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (accept) begin
                rd_tag[w] <= tag_mem[w][in_addr.cache.index];
            end
            if (tag_wen && look.victim_way == way_idx_t'(w)) begin
                tag_mem[w][idx] <= req.addr.cache.tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_q[w] <= '0;
            end
            lru_root   <= '0;
            lru_grp[0] <= '0;
            lru_grp[1] <= '0;
        end else if (tag_wen) begin
            valid_q[look.victim_way][idx] <= 1'b1;
            // flip root and the group bit on the victim path
            lru_root[idx]      <= ~lru_root[idx];
            lru_grp[root][idx] <= ~lru_grp[root][idx];
        end else if (lookup_en && look.hit) begin
            // point both levels away from the hit way
            lru_root[idx]                  <= ~look.hit_way[1];
            lru_grp[look.hit_way[1]][idx] <= ~look.hit_way[0];
        end
    end

    always_comb begin
        look.hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = valid_q[w][idx] && (rd_tag[w] == req.addr.cache.tag);
            if (hit_vec[w]) begin
                look.hit_way = way_idx_t'(w);
            end
        end
        look.hit        = |hit_vec;
        look.victim_way = {root, lru_grp[root][idx]};
    end

endmodule

// ==== icache_refill_ctrl.sv ====
`timescale 1ns/1ps

module icache_refill_ctrl
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_req,
    input  fetch_req_t req,
    input  word_t      mapped_addr,
    input  lookup_t    look,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    output word_t      araddr,
    output logic [7:0] arlen,
    output logic [1:0] arburst,
    output logic       arvalid,
    output logic       accept,
    output logic       lookup_en,
    output logic       tag_wen,
    output logic       inst_data_ok,
    output logic       data_ready_sel,
    output beat_wr_t   beat,
    output word_t      held_word
);

    ctrl_state_e          state;
    ctrl_state_e          state_nxt;
    logic [word_bits-1:0] beat_cnt;
    cache_addr_t          line_addr;

    assign inst_data_ok   = (state == lookup && req.cached && look.hit) || state == data_ready;
    assign accept         = inst_req && (state == idle || inst_data_ok);
    assign lookup_en      = (state == lookup) && req.cached;
    assign tag_wen        = (state == tag_update);
    assign data_ready_sel = (state == data_ready);

    // refill starts at word 0 of the line
    always_comb begin
        line_addr          = req.addr.cache;
        line_addr.word_off = '0;
        line_addr.byte_off = '0;
    end

    assign arvalid = (state == single_ar) || (state == line_ar);
    assign araddr  = (state == line_ar) ? word_t'(line_addr) : mapped_addr;
    assign arlen   = (state == line_ar) ? burst_len_cached : burst_len_single;
    assign arburst = (state == line_ar) ? burst_incr : burst_fixed;

    always_comb begin
        beat.wen  = (state == line_r) && rvalid;
        beat.way  = look.victim_way;
        beat.word = beat_cnt;
        beat.data = rdata;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_nxt = lookup;
                end
            end
            // uncached requests pass through lookup without effect
            lookup: begin
                if (!req.cached) begin
                    state_nxt = single_ar;
                end else if (!look.hit) begin
                    state_nxt = line_ar;
                end else if (!accept) begin
                    state_nxt = idle;
                end
            end
            single_ar: begin
                if (arready) begin
                    state_nxt = single_r;
                end
            end
            single_r: begin
                if (rvalid) begin
                    state_nxt = data_ready;
                end
            end
            line_ar: begin
                if (arready) begin
                    state_nxt = line_r;
                end
            end
            line_r: begin
                if (rvalid && rlast) begin
                    state_nxt = tag_update;
                end
            end
            tag_update: state_nxt = data_ready;
            data_ready: state_nxt = accept ? lookup : idle;
            default:    state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == line_ar) begin
                beat_cnt <= '0;
            end else if (beat.wen) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // critical word of the burst, or the single read word
    always_ff @(posedge clk) begin
        if (state == single_r && rvalid) begin
            held_word <= rdata;
        end else if (beat.wen && beat_cnt == req.addr.cache.word_off) begin
            held_word <= rdata;
        end
    end

endmodule

// ==== icache_data_ways.sv ====
`timescale 1ns/1ps

module icache_data_ways
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       accept,
    input  word_t      inst_addr,
    input  fetch_req_t req,
    input  lookup_t    look,
    input  beat_wr_t   beat,
    input  word_t      held_word,
    input  logic       data_ready_sel,
    output word_t      inst_rdata
);

    fetch_addr_u                     in_addr;
    word_t                           mem [num_ways][num_sets*line_words];
    word_t                           rd_word [num_ways];
    logic [index_bits+word_bits-1:0] rd_ptr;
    logic [index_bits+word_bits-1:0] wr_ptr;

    assign in_addr = inst_addr;
    assign rd_ptr  = {in_addr.cache.index, in_addr.cache.word_off};
    assign wr_ptr  = {req.addr.cache.index, beat.word};

    // every way reads the addressed word, refill writes one beat per cycle
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (accept) begin
                rd_word[w] <= mem[w][rd_ptr];
            end
            if (beat.wen && beat.way == way_idx_t'(w)) begin
                mem[w][wr_ptr] <= beat.data;
            end
        end
    end

    assign inst_rdata = data_ready_sel ? held_word : rd_word[look.hit_way];

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_req,
    input  word_t      inst_addr,
    input  logic       inst_cached,
    output logic       inst_data_ok,
    output word_t      inst_rdata,
    output word_t      araddr,
    output logic [7:0] arlen,
    output logic [1:0] arburst,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rlast,
    input  logic       rvalid
);

    fetch_req_t req;
    word_t      mapped_addr;
    lookup_t    look;
    beat_wr_t   beat;
    word_t      held_word;
    logic       accept;
    logic       lookup_en;
    logic       tag_wen;
    logic       data_ready_sel;

    icache_addr_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .accept      (accept),
        .inst_addr   (inst_addr),
        .inst_cached (inst_cached),
        .req         (req),
        .mapped_addr (mapped_addr)
    );

    icache_tag_lru u_tag_lru (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .inst_addr (inst_addr),
        .req       (req),
        .lookup_en (lookup_en),
        .tag_wen   (tag_wen),
        .look      (look)
    );

    icache_refill_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .inst_req       (inst_req),
        .req            (req),
        .mapped_addr    (mapped_addr),
        .look           (look),
        .arready        (arready),
        .rdata          (rdata),
        .rlast          (rlast),
        .rvalid         (rvalid),
        .araddr         (araddr),
        .arlen          (arlen),
        .arburst        (arburst),
        .arvalid        (arvalid),
        .accept         (accept),
        .lookup_en      (lookup_en),
        .tag_wen        (tag_wen),
        .inst_data_ok   (inst_data_ok),
        .data_ready_sel (data_ready_sel),
        .beat           (beat),
        .held_word      (held_word)
    );

    icache_data_ways u_data_ways (
        .clk            (clk),
        .accept         (accept),
        .inst_addr      (inst_addr),
        .req            (req),
        .look           (look),
        .beat           (beat),
        .held_word      (held_word),
        .data_ready_sel (data_ready_sel),
        .inst_rdata     (inst_rdata)
    );

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_t      data_pattern,
    input  word_t      araddr,
    input  logic [7:0] arlen,
    input  logic [1:0] arburst,
    input  logic       arvalid,
    output logic       arready,
    output word_t      rdata,
    output logic       rlast,
    output logic       rvalid,
    output integer     ar_count,
    output word_t      last_araddr,
    output logic [7:0] last_arlen,
    output logic [1:0] last_arburst
);

    logic [31:0] lcg_state;
    logic        busy;
    word_t       base;
    logic [7:0]  len;
    logic [1:0]  burst;
    logic [7:0]  beat_idx;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t beat_addr(input word_t b, input logic [1:0] kind,
                                        input logic [7:0] n);
        if (kind == burst_incr) begin
            return b + {22'd0, n, 2'b00};
        end
        return b;
    endfunction

    initial begin
        lcg_state    = 32'd94978;
        busy         = 1'b0;
        base         = '0;
        len          = '0;
        burst        = '0;
        beat_idx     = '0;
        arready      = 1'b0;
        rvalid       = 1'b0;
        rlast        = 1'b0;
        rdata        = '0;
        ar_count     = 0;
        last_araddr  = '0;
        last_arlen   = '0;
        last_arburst = '0;
    end

    // transfers are judged on the values held up to this edge
    always @(posedge clk) begin
        if (rst) begin
            busy     = 1'b0;
            ar_count = 0;
        end else begin
            if (rvalid) begin
                if (rlast) begin
                    busy = 1'b0;
                end
                beat_idx = beat_idx + 8'd1;
            end
            if (arvalid && arready) begin
                busy         = 1'b1;
                base         = araddr;
                len          = arlen;
                burst        = arburst;
                beat_idx     = '0;
                ar_count     = ar_count + 1;
                last_araddr  = araddr;
                last_arlen   = arlen;
                last_arburst = arburst;
            end
        end
        #2;
        // roughly one stall in four on each channel
        lcg_state = lcg_next(lcg_state);
        arready   = !rst && !busy && (lcg_state[17:16] != 2'b00);
        rvalid    = busy && (lcg_state[25:24] != 2'b00);
        rlast     = busy && (beat_idx == len);
        rdata     = beat_addr(base, burst, beat_idx) ^ data_pattern;
    end

endmodule

// ==== tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache
    import icache_pkg::*;
();

    typedef struct packed {
        word_t addr;
        logic  cached;
        logic  b2b;
    } row_t;

    logic       clk;
    logic       rst;
    logic       inst_req;
    word_t      inst_addr;
    logic       inst_cached;
    logic       inst_data_ok;
    word_t      inst_rdata;
    word_t      araddr;
    logic [7:0] arlen;
    logic [1:0] arburst;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic       rlast;
    logic       rvalid;
    integer     ar_count;
    word_t      last_araddr;
    logic [7:0] last_arlen;
    logic [1:0] last_arburst;
    word_t      data_pattern;

    row_t                rows [$];
    logic [tag_bits-1:0] ref_tag [num_sets][num_ways];
    logic                ref_valid [num_sets][num_ways];
    logic                ref_root [num_sets];
    logic [1:0]          ref_grp [num_sets];

    icache_top DUT (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_cached  (inst_cached),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .araddr       (araddr),
        .arlen        (arlen),
        .arburst      (arburst),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid)
    );

    tb_axi_mem u_mem (
        .clk          (clk),
        .rst          (rst),
        .data_pattern (data_pattern),
        .araddr       (araddr),
        .arlen        (arlen),
        .arburst      (arburst),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .ar_count     (ar_count),
        .last_araddr  (last_araddr),
        .last_arlen   (last_arlen),
        .last_arburst (last_arburst)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input integer got, input integer exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic add_row(input word_t a, input logic c, input logic b);
        row_t r;
        r.addr   = a;
        r.cached = c;
        r.b2b    = b;
        rows.push_back(r);
    endtask

    task automatic load_table();
        // cold miss, then hits in the same line
        add_row(32'h0000_10a0, 1'b1, 1'b0);
        add_row(32'h0000_10a8, 1'b1, 1'b0);
        add_row(32'h0000_10bc, 1'b1, 1'b0);
        add_row(32'h0000_10a4, 1'b1, 1'b1);
        add_row(32'h0000_10b0, 1'b1, 1'b1);
        add_row(32'h0000_10ac, 1'b1, 1'b1);
        // uncached reads leave the line unallocated
        add_row(32'ha000_20c4, 1'b0, 1'b0);
        add_row(32'h0000_20c4, 1'b1, 1'b0);
        add_row(32'h0000_20c8, 1'b1, 1'b1);
        add_row(32'h8000_3000, 1'b0, 1'b0);
        add_row(32'h1fc0_0010, 1'b0, 1'b1);
        add_row(32'h9fc0_0010, 1'b0, 1'b0);
        // five tags competing for set 5
        add_row(32'h0000_30a0, 1'b1, 1'b0);
        add_row(32'h0000_40a4, 1'b1, 1'b1);
        add_row(32'h0000_10b8, 1'b1, 1'b0);
        add_row(32'h0000_50a4, 1'b1, 1'b0);
        add_row(32'h0000_60a8, 1'b1, 1'b0);
        add_row(32'h0000_30bc, 1'b1, 1'b0);
        add_row(32'h0000_40a0, 1'b1, 1'b1);
        add_row(32'h0000_10a0, 1'b1, 1'b0);
        add_row(32'h0000_60b4, 1'b1, 1'b1);
    endtask

    task automatic clear_model();
        for (int s = 0; s < num_sets; s++) begin
            ref_root[s] = 1'b0;
            ref_grp[s]  = 2'b00;
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
    endtask

    // tree pseudo-LRU with the victim at {root, group bit under root}
    task automatic model_access(input word_t addr, output logic hit);
        cache_addr_t a;
        way_idx_t    v;
        int          w;
        a   = addr;
        hit = 1'b0;
        v   = '0;
        for (w = 0; w < num_ways; w++) begin
            if (ref_valid[a.index][w] && ref_tag[a.index][w] == a.tag) begin
                hit = 1'b1;
                v   = way_idx_t'(w);
            end
        end
        if (hit) begin
            ref_root[a.index]      = ~v[1];
            ref_grp[a.index][v[1]] = ~v[0];
        end else begin
            v                         = {ref_root[a.index], ref_grp[a.index][ref_root[a.index]]};
            ref_tag[a.index][v]       = a.tag;
            ref_valid[a.index][v]     = 1'b1;
            ref_grp[a.index][v[1]]    = ~ref_grp[a.index][v[1]];
            ref_root[a.index]         = ~ref_root[a.index];
        end
    endtask

    function automatic word_t phys_addr(input word_t a);
        seg_addr_t s;
        s = a;
        if (s.segment == 3'b100 || s.segment == 3'b101) begin
            return {3'b000, s.phys};
        end
        return a;
    endfunction

    task automatic drive_request(input row_t r);
        inst_req    = 1'b1;
        inst_addr   = r.addr;
        inst_cached = r.cached;
    endtask

    task automatic wait_data_ok(output integer cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            #2;
            inst_req = 1'b0;
            cycles   = cycles + 1;
        end while (!inst_data_ok && cycles < 200);
        if (!inst_data_ok) begin
            abort_run($sformatf("timeout: no inst_data_ok within %0d cycles at time %0t",
                                cycles, $time));
        end
    endtask

    initial begin
        int     i;
        integer cycles;
        integer exp_ar;
        logic   exp_hit;
        row_t   row;
        word_t  exp_word;
        clk          = 1'b0;
        rst          = 1'b1;
        inst_req     = 1'b0;
        inst_addr    = '0;
        inst_cached  = 1'b0;
        data_pattern = 32'h5a3c_96e1;
        exp_ar       = 0;
        clear_model();
        load_table();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        drive_request(rows[0]);
        for (i = 0; i < rows.size(); i++) begin
            wait_data_ok(cycles);
            row     = rows[i];
            exp_hit = 1'b0;
            if (row.cached) begin
                model_access(row.addr, exp_hit);
                exp_word = {row.addr[31:2], 2'b00} ^ data_pattern;
            end else begin
                exp_word = phys_addr(row.addr) ^ data_pattern;
            end
            if (!exp_hit) begin
                exp_ar = exp_ar + 1;
            end
            check_word("inst_rdata", inst_rdata, exp_word);
            check_count("ar_count", ar_count, exp_ar);
            // a hit answers one cycle after acceptance
            if (row.cached) begin
                check_count("hit", integer'(cycles == 1), integer'(exp_hit));
            end
            // 8-beat INCR line burst, single-beat FIXED uncached read
            if (!exp_hit && row.cached) begin
                check_word("araddr", last_araddr, {row.addr[31:5], 5'b00000});
                check_count("arlen", integer'(last_arlen), 7);
                check_count("arburst", integer'(last_arburst), integer'(2'b01));
            end else if (!row.cached) begin
                check_word("araddr", last_araddr, phys_addr(row.addr));
                check_count("arlen", integer'(last_arlen), 0);
                check_count("arburst", integer'(last_arburst), integer'(2'b00));
            end
            if (i + 1 < rows.size()) begin
                if (!rows[i+1].b2b) begin
                    @(posedge clk);
                    #2;
                end
                drive_request(rows[i+1]);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
icache_pkg.sv
icache_addr_decode.sv
icache_tag_lru.sv
icache_refill_ctrl.sv
icache_data_ways.sv
icache_top.sv
tb_axi_mem.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - icache_pkg.sv
      - icache_addr_decode.sv
      - icache_tag_lru.sv
      - icache_refill_ctrl.sv
      - icache_data_ways.sv
      - icache_top.sv
  - target: simulation
    files:
      - tb_axi_mem.sv
      - tb_icache.sv
